/* logic/isa_pkg.sv */
package isa_pkg;

    localparam int XLEN         = 32;
    localparam int ADDR_WIDTH   = 32;
    localparam int REG_ID_WIDTH = 5;
    localparam int MASK_WIDTH   = XLEN / 8;
    localparam int BYTE_SEL_WIDTH = $clog2(MASK_WIDTH);

    // Bit positions of the instruction fields.
    localparam int OPC_WIDTH  = 7;
    localparam int RD_LSB     = 7;
    localparam int FUNCT3_LSB = 12;
    localparam int RS1_LSB    = 15;
    localparam int RS2_LSB    = 20;
    localparam int FUNCT7_LSB = 25;

    localparam logic [OPC_WIDTH - 1 : 0] OPC_OP     = 7'b0110011;
    localparam logic [OPC_WIDTH - 1 : 0] OPC_OP_IMM = 7'b0010011;
    localparam logic [OPC_WIDTH - 1 : 0] OPC_LUI    = 7'b0110111;
    localparam logic [OPC_WIDTH - 1 : 0] OPC_LOAD   = 7'b0000011;
    localparam logic [OPC_WIDTH - 1 : 0] OPC_STORE  = 7'b0100011;
    localparam logic [OPC_WIDTH - 1 : 0] OPC_BRANCH = 7'b1100011;
    localparam logic [OPC_WIDTH - 1 : 0] OPC_JAL    = 7'b1101111;
    localparam logic [OPC_WIDTH - 1 : 0] OPC_SYSTEM = 7'b1110011;

    localparam logic [2 : 0] F3_ADD_SUB = 3'b000;
    localparam logic [2 : 0] F3_SLT     = 3'b010;
    localparam logic [2 : 0] F3_XOR     = 3'b100;
    localparam logic [2 : 0] F3_OR      = 3'b110;
    localparam logic [2 : 0] F3_AND     = 3'b111;
    localparam logic [2 : 0] F3_LW      = 3'b010;
    localparam logic [2 : 0] F3_LBU     = 3'b100;
    localparam logic [2 : 0] F3_SW      = 3'b010;
    localparam logic [2 : 0] F3_SB      = 3'b000;
    localparam logic [2 : 0] F3_BEQ     = 3'b000;
    localparam logic [2 : 0] F3_BNE     = 3'b001;
    localparam logic [2 : 0] F3_PRIV    = 3'b000;

    localparam logic [6 : 0]  F7_BASE    = 7'b0000000;
    localparam logic [6 : 0]  F7_SUB     = 7'b0100000;
    localparam logic [11 : 0] F12_EBREAK = 12'h001;

    localparam int END_REG = 10;

endpackage

/* logic/core_pkg.sv */
package core_pkg;

    typedef enum logic [2 : 0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_PASS_B
    } alu_op_e;

    typedef enum logic [1 : 0] {
        BR_NONE,
        BR_EQ,
        BR_NE,
        BR_JUMP
    } branch_e;

    typedef enum logic [2 : 0] {
        MEM_NONE,
        MEM_LOAD_WORD,
        MEM_LOAD_BYTE_U,
        MEM_STORE_WORD,
        MEM_STORE_BYTE
    } mem_op_e;

    typedef enum logic [1 : 0] {
        WB_ALU,
        WB_MEM,
        WB_LINK
    } wb_src_e;

    localparam logic [isa_pkg::ADDR_WIDTH - 1 : 0] RESET_PC = '0;

endpackage

/* logic/decode_if.sv */
`timescale 1ns/1ps

interface decode_if;
    import isa_pkg::*;
    import core_pkg::*;

    alu_op_e                     alu_op;
    logic [XLEN - 1 : 0]         operand_a;
    logic [XLEN - 1 : 0]         operand_b;
    logic [XLEN - 1 : 0]         imm;
    logic [XLEN - 1 : 0]         store_data;
    branch_e                     branch;
    mem_op_e                     mem_op;
    wb_src_e                     wb_src;
    logic [REG_ID_WIDTH - 1 : 0] rd_id;
    logic                        reg_wr_en;

    modport src (
        output alu_op, operand_a, operand_b, imm, store_data,
        output branch, mem_op, wb_src, rd_id, reg_wr_en
    );

    // Execute only needs what drives the ALU and the next PC.
    modport exec (
        input alu_op, operand_a, operand_b, imm, branch
    );

    modport wb (
        input store_data, mem_op, wb_src, rd_id, reg_wr_en
    );

endinterface

/* logic/decode_unit.sv */
`timescale 1ns/1ps

module decode_unit (
    input  logic                                 i_sys_clk,
    input  logic                                 i_reset,

    input  logic [isa_pkg::XLEN - 1 : 0]         i_inst,

    input  logic                                 i_gpr_wr_en,
    input  logic [isa_pkg::REG_ID_WIDTH - 1 : 0] i_gpr_wr_id,
    input  logic [isa_pkg::XLEN - 1 : 0]         i_gpr_wr_data,

    decode_if.src                                ctrl,

    output logic                                 o_end_flag,
    output logic [isa_pkg::XLEN - 1 : 0]         o_end_data
);
    import isa_pkg::*;
    import core_pkg::*;

    logic [XLEN - 1 : 0]         gpr [2 ** REG_ID_WIDTH];

    logic [OPC_WIDTH - 1 : 0]    opcode;
    logic [2 : 0]                funct3;
    logic [6 : 0]                funct7;
    logic [REG_ID_WIDTH - 1 : 0] rs1_id;
    logic [REG_ID_WIDTH - 1 : 0] rs2_id;
    logic [XLEN - 1 : 0]         rs1_data;
    logic [XLEN - 1 : 0]         rs2_data;
    logic [XLEN - 1 : 0]         imm_i;
    logic [XLEN - 1 : 0]         imm_s;
    logic [XLEN - 1 : 0]         imm_b;
    logic [XLEN - 1 : 0]         imm_j;
    logic [XLEN - 1 : 0]         imm_u;
    logic                        use_imm;

    assign opcode = i_inst[OPC_WIDTH - 1 : 0];
    assign funct3 = i_inst[FUNCT3_LSB +: 3];
    assign funct7 = i_inst[FUNCT7_LSB +: 7];
    assign rs1_id = i_inst[RS1_LSB +: REG_ID_WIDTH];
    assign rs2_id = i_inst[RS2_LSB +: REG_ID_WIDTH];

    assign imm_i = {{20{i_inst[31]}}, i_inst[31 : 20]};
    assign imm_s = {{20{i_inst[31]}}, i_inst[31 : 25], i_inst[11 : 7]};
    assign imm_b = {{19{i_inst[31]}}, i_inst[31], i_inst[7], i_inst[30 : 25], i_inst[11 : 8], 1'b0};
    assign imm_j = {{11{i_inst[31]}}, i_inst[31], i_inst[19 : 12], i_inst[20], i_inst[30 : 21], 1'b0};
    assign imm_u = {i_inst[31 : 12], 12'b0};

    // Register x0 is hardwired to zero on the read side.
    assign rs1_data   = (rs1_id == '0) ? '0 : gpr[rs1_id];
    assign rs2_data   = (rs2_id == '0) ? '0 : gpr[rs2_id];
    assign o_end_data = gpr[END_REG];

    always_ff @(posedge i_sys_clk) begin
        if (i_reset) begin
            for (int i = 0; i < 2 ** REG_ID_WIDTH; i++) begin
                gpr[i] <= '0;
            end
        end else if (i_gpr_wr_en && (i_gpr_wr_id != '0)) begin
            gpr[i_gpr_wr_id] <= i_gpr_wr_data;
        end
    end

    // Anything not recognised falls through the defaults and retires as a no-op.
    always_comb begin
        ctrl.alu_op    = ALU_ADD;
        ctrl.imm       = '0;
        ctrl.branch    = BR_NONE;
        ctrl.mem_op    = MEM_NONE;
        ctrl.wb_src    = WB_ALU;
        ctrl.reg_wr_en = 1'b0;
        use_imm        = 1'b0;
        o_end_flag     = 1'b0;
        case (opcode)
            OPC_OP: begin
                ctrl.reg_wr_en = 1'b1;
                case ({funct7, funct3})
                    {F7_BASE, F3_ADD_SUB}: ctrl.alu_op = ALU_ADD;
                    {F7_SUB,  F3_ADD_SUB}: ctrl.alu_op = ALU_SUB;
                    {F7_BASE, F3_SLT}:     ctrl.alu_op = ALU_SLT;
                    {F7_BASE, F3_XOR}:     ctrl.alu_op = ALU_XOR;
                    {F7_BASE, F3_OR}:      ctrl.alu_op = ALU_OR;
                    {F7_BASE, F3_AND}:     ctrl.alu_op = ALU_AND;
                    default:               ctrl.reg_wr_en = 1'b0;
                endcase
            end
            OPC_OP_IMM: begin
                ctrl.imm       = imm_i;
                use_imm        = 1'b1;
                ctrl.reg_wr_en = 1'b1;
                case (funct3)
                    F3_ADD_SUB: ctrl.alu_op = ALU_ADD;
                    F3_XOR:     ctrl.alu_op = ALU_XOR;
                    F3_OR:      ctrl.alu_op = ALU_OR;
                    F3_AND:     ctrl.alu_op = ALU_AND;
                    default:    ctrl.reg_wr_en = 1'b0;
                endcase
            end
            OPC_LUI: begin
                ctrl.imm       = imm_u;
                use_imm        = 1'b1;
                ctrl.alu_op    = ALU_PASS_B;
                ctrl.reg_wr_en = 1'b1;
            end
            OPC_LOAD: begin
                ctrl.imm    = imm_i;
                use_imm     = 1'b1;
                ctrl.wb_src = WB_MEM;
                if (funct3 == F3_LW) begin
                    ctrl.mem_op    = MEM_LOAD_WORD;
                    ctrl.reg_wr_en = 1'b1;
                end else if (funct3 == F3_LBU) begin
                    ctrl.mem_op    = MEM_LOAD_BYTE_U;
                    ctrl.reg_wr_en = 1'b1;
                end
            end
            OPC_STORE: begin
                ctrl.imm = imm_s;
                use_imm  = 1'b1;
                if (funct3 == F3_SW) begin
                    ctrl.mem_op = MEM_STORE_WORD;
                end else if (funct3 == F3_SB) begin
                    ctrl.mem_op = MEM_STORE_BYTE;
                end
            end
            OPC_BRANCH: begin
                // Operands stay rs1 and rs2 so execute can compare them.
                ctrl.imm = imm_b;
                if (funct3 == F3_BEQ) begin
                    ctrl.branch = BR_EQ;
                end else if (funct3 == F3_BNE) begin
                    ctrl.branch = BR_NE;
                end
            end
            OPC_JAL: begin
                ctrl.imm       = imm_j;
                ctrl.branch    = BR_JUMP;
                ctrl.wb_src    = WB_LINK;
                ctrl.reg_wr_en = 1'b1;
            end
            OPC_SYSTEM: begin
                if (funct3 == F3_PRIV && i_inst[XLEN - 1 : RS2_LSB] == F12_EBREAK) begin
                    o_end_flag = 1'b1;
                end
            end
            default: begin
            end
        endcase
    end

    assign ctrl.operand_a  = rs1_data;
    assign ctrl.operand_b  = use_imm ? ctrl.imm : rs2_data;
    assign ctrl.store_data = rs2_data;
    assign ctrl.rd_id      = i_inst[RD_LSB +: REG_ID_WIDTH];

endmodule

/* logic/execute_unit.sv */
`timescale 1ns/1ps

module execute_unit (
    input  logic                               i_sys_clk,
    input  logic                               i_reset,

    decode_if.exec                             ctrl,

    output logic [isa_pkg::ADDR_WIDTH - 1 : 0] o_pc,
    output logic [isa_pkg::XLEN - 1 : 0]       o_alu_result,
    output logic [isa_pkg::ADDR_WIDTH - 1 : 0] o_link_addr
);
    import isa_pkg::*;
    import core_pkg::*;

    logic                      operands_equal;
    logic                      taken;
    logic [ADDR_WIDTH - 1 : 0] target;

    always_comb begin
        case (ctrl.alu_op)
            ALU_ADD:    o_alu_result = ctrl.operand_a + ctrl.operand_b;
            ALU_SUB:    o_alu_result = ctrl.operand_a - ctrl.operand_b;
            ALU_AND:    o_alu_result = ctrl.operand_a & ctrl.operand_b;
            ALU_OR:     o_alu_result = ctrl.operand_a | ctrl.operand_b;
            ALU_XOR:    o_alu_result = ctrl.operand_a ^ ctrl.operand_b;
            ALU_SLT: begin
                o_alu_result = {{(XLEN - 1){1'b0}},
                                ($signed(ctrl.operand_a) < $signed(ctrl.operand_b))};
            end
            ALU_PASS_B: o_alu_result = ctrl.operand_b;
            default:    o_alu_result = '0;
        endcase
    end

    assign operands_equal = (ctrl.operand_a == ctrl.operand_b);

    always_comb begin
        case (ctrl.branch)
            BR_EQ:   taken = operands_equal;
            BR_NE:   taken = !operands_equal;
            BR_JUMP: taken = 1'b1;
            default: taken = 1'b0;
        endcase
    end

    // Branch and JAL targets are both relative to the current PC.
    assign target      = o_pc + ctrl.imm;
    assign o_link_addr = o_pc + 4;

    always_ff @(posedge i_sys_clk) begin
        if (i_reset) begin
            o_pc <= RESET_PC;
        end else if (taken) begin
            o_pc <= target;
        end else begin
            o_pc <= o_link_addr;
        end
    end

endmodule

/* logic/result_unit.sv */
`timescale 1ns/1ps

module result_unit (
    input  logic                                 i_reset,

    decode_if.wb                                 ctrl,

    input  logic [isa_pkg::XLEN - 1 : 0]         i_alu_result,
    input  logic [isa_pkg::ADDR_WIDTH - 1 : 0]   i_link_addr,
    input  logic [isa_pkg::XLEN - 1 : 0]         i_ram_rd_data,

    output logic                                 o_ram_rd_en,
    output logic [isa_pkg::ADDR_WIDTH - 1 : 0]   o_ram_rd_addr,
    output logic                                 o_ram_wr_en,
    output logic [isa_pkg::ADDR_WIDTH - 1 : 0]   o_ram_wr_addr,
    output logic [isa_pkg::XLEN - 1 : 0]         o_ram_wr_data,
    output logic [isa_pkg::MASK_WIDTH - 1 : 0]   o_ram_wr_mask,

    output logic                                 o_gpr_wr_en,
    output logic [isa_pkg::REG_ID_WIDTH - 1 : 0] o_gpr_wr_id,
    output logic [isa_pkg::XLEN - 1 : 0]         o_gpr_wr_data
);
    import isa_pkg::*;
    import core_pkg::*;

    logic [BYTE_SEL_WIDTH - 1 : 0] byte_sel;
    logic [XLEN - 1 : 0]           load_data;

    assign byte_sel      = i_alu_result[BYTE_SEL_WIDTH - 1 : 0];
    assign o_ram_rd_addr = i_alu_result;
    assign o_ram_wr_addr = i_alu_result;

    assign o_ram_rd_en = !i_reset && (ctrl.mem_op == MEM_LOAD_WORD ||
                                      ctrl.mem_op == MEM_LOAD_BYTE_U);
    assign o_ram_wr_en = !i_reset && (ctrl.mem_op == MEM_STORE_WORD ||
                                      ctrl.mem_op == MEM_STORE_BYTE);

    // A byte store puts the byte on every lane and lets the mask pick one.
    always_comb begin
        case (ctrl.mem_op)
            MEM_STORE_WORD: begin
                o_ram_wr_data = ctrl.store_data;
                o_ram_wr_mask = '1;
            end
            MEM_STORE_BYTE: begin
                o_ram_wr_data = {MASK_WIDTH{ctrl.store_data[7 : 0]}};
                o_ram_wr_mask = {{(MASK_WIDTH - 1){1'b0}}, 1'b1} << byte_sel;
            end
            default: begin
                o_ram_wr_data = ctrl.store_data;
                o_ram_wr_mask = '0;
            end
        endcase
    end

    assign load_data = (ctrl.mem_op == MEM_LOAD_BYTE_U) ?
                       {{(XLEN - 8){1'b0}}, i_ram_rd_data[8 * byte_sel +: 8]} : i_ram_rd_data;

    always_comb begin
        case (ctrl.wb_src)
            WB_MEM:  o_gpr_wr_data = load_data;
            WB_LINK: o_gpr_wr_data = i_link_addr;
            default: o_gpr_wr_data = i_alu_result;
        endcase
    end

    assign o_gpr_wr_en = ctrl.reg_wr_en && !i_reset;
    assign o_gpr_wr_id = ctrl.rd_id;

endmodule

/* logic/cpu.sv */
`timescale 1ns/1ps

module cpu (
    input  logic                               i_sys_clk,
    input  logic                               i_reset,

    input  logic [isa_pkg::XLEN - 1 : 0]       i_rom_rd_data,
    output logic [isa_pkg::ADDR_WIDTH - 1 : 0] o_rom_rd_addr,

    input  logic [isa_pkg::XLEN - 1 : 0]       i_ram_rd_data,
    output logic                               o_ram_rd_en,
    output logic [isa_pkg::ADDR_WIDTH - 1 : 0] o_ram_rd_addr,
    output logic                               o_ram_wr_en,
    output logic [isa_pkg::ADDR_WIDTH - 1 : 0] o_ram_wr_addr,
    output logic [isa_pkg::XLEN - 1 : 0]       o_ram_wr_data,
    output logic [isa_pkg::MASK_WIDTH - 1 : 0] o_ram_wr_mask,

    output logic                               o_end_flag,
    output logic [isa_pkg::XLEN - 1 : 0]       o_end_data
);
    import isa_pkg::*;

    logic [XLEN - 1 : 0]         w_alu_result;
    logic [ADDR_WIDTH - 1 : 0]   w_link_addr;
    logic                        w_gpr_wr_en;
    logic [REG_ID_WIDTH - 1 : 0] w_gpr_wr_id;
    logic [XLEN - 1 : 0]         w_gpr_wr_data;

    decode_if ctrl_if ();

    decode_unit u_decode (
        .i_sys_clk    (i_sys_clk    ),
        .i_reset      (i_reset      ),
        .i_inst       (i_rom_rd_data),
        .i_gpr_wr_en  (w_gpr_wr_en  ),
        .i_gpr_wr_id  (w_gpr_wr_id  ),
        .i_gpr_wr_data(w_gpr_wr_data),
        .ctrl         (ctrl_if      ),
        .o_end_flag   (o_end_flag   ),
        .o_end_data   (o_end_data   )
    );

    // The PC register output addresses the instruction ROM directly.
    execute_unit u_execute (
        .i_sys_clk   (i_sys_clk    ),
        .i_reset     (i_reset      ),
        .ctrl        (ctrl_if      ),
        .o_pc        (o_rom_rd_addr),
        .o_alu_result(w_alu_result ),
        .o_link_addr (w_link_addr  )
    );

    result_unit u_result (
        .i_reset      (i_reset      ),
        .ctrl         (ctrl_if      ),
        .i_alu_result (w_alu_result ),
        .i_link_addr  (w_link_addr  ),
        .i_ram_rd_data(i_ram_rd_data),
        .o_ram_rd_en  (o_ram_rd_en  ),
        .o_ram_rd_addr(o_ram_rd_addr),
        .o_ram_wr_en  (o_ram_wr_en  ),
        .o_ram_wr_addr(o_ram_wr_addr),
        .o_ram_wr_data(o_ram_wr_data),
        .o_ram_wr_mask(o_ram_wr_mask),
        .o_gpr_wr_en  (w_gpr_wr_en  ),
        .o_gpr_wr_id  (w_gpr_wr_id  ),
        .o_gpr_wr_data(w_gpr_wr_data)
    );

endmodule

/* testbench/clock_gen.sv */
`timescale 1ns/1ps

module clock_gen (
    output logic o_clk
);
    localparam int HALF_PERIOD_NS = 50;

    initial begin
        o_clk = 1'b0;
        forever begin
            #HALF_PERIOD_NS o_clk = ~o_clk;
        end
    end

endmodule

/* testbench/cpu_props.sv */
`timescale 1ns/1ps

module cpu_props (
    input logic                               i_sys_clk,
    input logic                               i_reset,
    input logic                               i_ram_rd_en,
    input logic                               i_ram_wr_en,
    input logic [isa_pkg::MASK_WIDTH - 1 : 0] i_ram_wr_mask,
    input logic [isa_pkg::ADDR_WIDTH - 1 : 0] i_rom_rd_addr
);
    import core_pkg::*;

    int fail_count = 0;

    no_ram_access_in_reset: assert property (@(posedge i_sys_clk)
        i_reset |-> !i_ram_rd_en && !i_ram_wr_en)
    else begin
        fail_count++;
        $error("RAM accessed while reset is asserted");
    end

    // A word store enables all lanes, a byte store exactly one.
    legal_write_mask: assert property (@(posedge i_sys_clk) disable iff (i_reset)
        i_ram_wr_en |-> (i_ram_wr_mask == '1) || $onehot(i_ram_wr_mask))
    else begin
        fail_count++;
        $error("RAM write mask is neither full nor one-hot");
    end

    aligned_fetch: assert property (@(posedge i_sys_clk) disable iff (i_reset)
        i_rom_rd_addr[1 : 0] == 2'b00)
    else begin
        fail_count++;
        $error("Instruction fetch address is not word aligned");
    end

    pc_after_reset: assert property (@(posedge i_sys_clk)
        $fell(i_reset) |-> i_rom_rd_addr == RESET_PC)
    else begin
        fail_count++;
        $error("PC does not start at the reset value");
    end

endmodule

/* testbench/cpu_checker.sv */
`timescale 1ns/1ps

module cpu_checker (
    input  logic                               i_sys_clk,
    input  logic                               i_reset,
    input  logic [isa_pkg::ADDR_WIDTH - 1 : 0] i_rom_rd_addr,
    input  logic [isa_pkg::XLEN - 1 : 0]       i_rom_rd_data,
    input  logic                               i_ram_rd_en,
    input  logic [isa_pkg::ADDR_WIDTH - 1 : 0] i_ram_rd_addr,
    input  logic                               i_ram_wr_en,
    input  logic [isa_pkg::ADDR_WIDTH - 1 : 0] i_ram_wr_addr,
    input  logic [isa_pkg::XLEN - 1 : 0]       i_ram_wr_data,
    input  logic [isa_pkg::MASK_WIDTH - 1 : 0] i_ram_wr_mask,
    input  logic                               i_end_flag,
    input  logic [isa_pkg::XLEN - 1 : 0]       i_end_data,
    output int                                 o_error_count
);
    import isa_pkg::*;
    import core_pkg::*;

    logic [31 : 0] regs [32];
    logic [31 : 0] ram [64];
    logic [31 : 0] pc;
    int            errors = 0;

    assign o_error_count = errors;

    task automatic compare(string what, logic [31 : 0] got, logic [31 : 0] expected);
        if (got !== expected) begin
            $display("CHECK FAILED at %0t ns: %s is %h, model expects %h",
                     $time, what, got, expected);
            errors++;
        end
    endtask

    // Executes the instruction at the model PC and checks the memory side of it.
    task automatic step();
        logic [31 : 0] inst;
        logic [31 : 0] a;
        logic [31 : 0] b;
        logic [31 : 0] addr;
        logic [31 : 0] word;
        logic [31 : 0] val;
        logic [31 : 0] data;
        logic [31 : 0] next_pc;
        logic [3 : 0]  mask;
        logic          rd_en;
        logic          wr_en;
        logic          wb;
        logic          stop;
        inst    = i_rom_rd_data;
        a       = regs[inst[19 : 15]];
        b       = regs[inst[24 : 20]];
        next_pc = pc + 32'd4;
        {rd_en, wr_en, wb, stop} = 4'b0000;
        {addr, val, data, mask} = '0;
        case (inst[6 : 0])
            OPC_OP: begin
                wb = 1'b1;
                case (inst[14 : 12])
                    F3_ADD_SUB: val = inst[30] ? a - b : a + b;
                    F3_SLT:     val = {31'b0, $signed(a) < $signed(b)};
                    F3_XOR:     val = a ^ b;
                    F3_OR:      val = a | b;
                    default:    val = a & b;
                endcase
            end
            OPC_OP_IMM: begin
                wb   = 1'b1;
                word = {{20{inst[31]}}, inst[31 : 20]};
                case (inst[14 : 12])
                    F3_ADD_SUB: val = a + word;
                    F3_XOR:     val = a ^ word;
                    F3_OR:      val = a | word;
                    default:    val = a & word;
                endcase
            end
            OPC_LUI: begin
                wb  = 1'b1;
                val = {inst[31 : 12], 12'b0};
            end
            OPC_LOAD: begin
                wb    = 1'b1;
                rd_en = 1'b1;
                addr  = a + {{20{inst[31]}}, inst[31 : 20]};
                word  = ram[addr[7 : 2]];
                val   = (inst[14 : 12] == F3_LBU) ? {24'b0, word[8 * addr[1 : 0] +: 8]} : word;
            end
            OPC_STORE: begin
                wr_en = 1'b1;
                addr  = a + {{20{inst[31]}}, inst[31 : 25], inst[11 : 7]};
                data  = (inst[14 : 12] == F3_SB) ? {4{b[7 : 0]}} : b;
                mask  = (inst[14 : 12] == F3_SB) ? 4'b0001 << addr[1 : 0] : 4'b1111;
                for (int k = 0; k < 4; k++) begin
                    if (mask[k]) begin
                        ram[addr[7 : 2]][8 * k +: 8] = data[8 * k +: 8];
                    end
                end
            end
            OPC_BRANCH: begin
                if ((inst[14 : 12] == F3_BEQ && a == b) || (inst[14 : 12] == F3_BNE && a != b)) begin
                    next_pc = pc + {{19{inst[31]}}, inst[31], inst[7], inst[30 : 25],
                                    inst[11 : 8], 1'b0};
                end
            end
            OPC_JAL: begin
                wb      = 1'b1;
                val     = pc + 32'd4;
                next_pc = pc + {{11{inst[31]}}, inst[31], inst[19 : 12], inst[20],
                                inst[30 : 21], 1'b0};
            end
            default: stop = (inst == 32'h0010_0073);
        endcase
        compare("PC", i_rom_rd_addr, pc);
        compare("RAM read enable", 32'(i_ram_rd_en), 32'(rd_en));
        compare("RAM write enable", 32'(i_ram_wr_en), 32'(wr_en));
        if (rd_en) begin
            compare("RAM read address", i_ram_rd_addr, addr);
        end
        if (wr_en) begin
            compare("RAM write address", i_ram_wr_addr, addr);
            compare("RAM write data", i_ram_wr_data, data);
            compare("RAM write mask", 32'(i_ram_wr_mask), 32'(mask));
        end
        compare("end flag", 32'(i_end_flag), 32'(stop));
        if (stop) begin
            compare("end data (x10)", i_end_data, regs[END_REG]);
        end
        if (wb && inst[11 : 7] != 5'd0) begin
            regs[inst[11 : 7]] = val;
        end
        pc = next_pc;
    endtask

    always @(negedge i_sys_clk) begin
        if (i_reset) begin
            compare("RAM read enable in reset", 32'(i_ram_rd_en), 32'd0);
            compare("RAM write enable in reset", 32'(i_ram_wr_en), 32'd0);
            pc = RESET_PC;
            for (int i = 0; i < 32; i++) begin
                regs[i] = '0;
            end
            for (int i = 0; i < 64; i++) begin
                ram[i] = {8'(i), ~8'(i), 8'(i + 64), 8'(i) ^ 8'h3c};
            end
        end else begin
            step();
        end
    end

endmodule

/* testbench/tb_cpu.sv */
`timescale 1ns/1ps

module tb_cpu;
    import isa_pkg::*;

    localparam int NUM_TESTS = 9;
    localparam int BODY_LEN  = 40;
    // Base setup, 14 register seeds, body, 15 stores and EBREAK.
    localparam int PROG_LEN        = 1 + 14 + BODY_LEN + 15 + 1;
    localparam int WATCHDOG_CYCLES = NUM_TESTS * (PROG_LEN + 10);
    localparam int RAM_BASE        = 32'h400;

    logic          clk;
    logic          reset;
    logic [31 : 0] rom [256] = '{default: '0};
    logic [31 : 0] ram [64] = '{default: '0};
    logic [31 : 0] rom_rd_addr;
    logic [31 : 0] rom_rd_data;
    logic [31 : 0] ram_rd_data;
    logic [31 : 0] ram_rd_addr;
    logic [31 : 0] ram_wr_addr;
    logic [31 : 0] ram_wr_data;
    logic [3 : 0]  ram_wr_mask;
    logic          ram_rd_en;
    logic          ram_wr_en;
    logic          end_flag;
    logic [31 : 0] end_data;
    int            error_count;
    int            next_slot;
    string         kind_names [3] = '{"ALU", "loads and stores", "control flow"};

    clock_gen clock_gen_inst (.o_clk(clk));

    cpu cpu_inst (
        .i_sys_clk    (clk        ),
        .i_reset      (reset      ),
        .i_rom_rd_data(rom_rd_data),
        .o_rom_rd_addr(rom_rd_addr),
        .i_ram_rd_data(ram_rd_data),
        .o_ram_rd_en  (ram_rd_en  ),
        .o_ram_rd_addr(ram_rd_addr),
        .o_ram_wr_en  (ram_wr_en  ),
        .o_ram_wr_addr(ram_wr_addr),
        .o_ram_wr_data(ram_wr_data),
        .o_ram_wr_mask(ram_wr_mask),
        .o_end_flag   (end_flag   ),
        .o_end_data   (end_data   )
    );

    cpu_checker cpu_checker_inst (
        .i_sys_clk    (clk        ),
        .i_reset      (reset      ),
        .i_rom_rd_addr(rom_rd_addr),
        .i_rom_rd_data(rom_rd_data),
        .i_ram_rd_en  (ram_rd_en  ),
        .i_ram_rd_addr(ram_rd_addr),
        .i_ram_wr_en  (ram_wr_en  ),
        .i_ram_wr_addr(ram_wr_addr),
        .i_ram_wr_data(ram_wr_data),
        .i_ram_wr_mask(ram_wr_mask),
        .i_end_flag   (end_flag   ),
        .i_end_data   (end_data   ),
        .o_error_count(error_count)
    );

    bind cpu cpu_props cpu_props_inst (
        .i_sys_clk    (i_sys_clk    ),
        .i_reset      (i_reset      ),
        .i_ram_rd_en  (o_ram_rd_en  ),
        .i_ram_wr_en  (o_ram_wr_en  ),
        .i_ram_wr_mask(o_ram_wr_mask),
        .i_rom_rd_addr(o_rom_rd_addr)
    );

    assign rom_rd_data = rom[rom_rd_addr[9 : 2]];
    assign ram_rd_data = ram[ram_rd_addr[7 : 2]];

    // The RAM window is refilled with an address pattern on every reset.
    always @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 64; i++) begin
                ram[i] <= {8'(i), ~8'(i), 8'(i + 64), 8'(i) ^ 8'h3c};
            end
        end else if (ram_wr_en) begin
            for (int k = 0; k < 4; k++) begin
                if (ram_wr_mask[k]) begin
                    ram[ram_wr_addr[7 : 2]][8 * k +: 8] <= ram_wr_data[8 * k +: 8];
                end
            end
        end
    end

    function automatic logic [31 : 0] r_type(logic [6 : 0] f7, logic [2 : 0] f3);
        return {f7, 5'($urandom % 16), 5'($urandom % 16), f3, rand_rd(), OPC_OP};
    endfunction

    function automatic logic [31 : 0] i_type(logic [11 : 0] imm, logic [4 : 0] rs1,
                                             logic [2 : 0] f3, logic [4 : 0] rd,
                                             logic [6 : 0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31 : 0] s_type(logic [11 : 0] imm, logic [4 : 0] rs2,
                                             logic [2 : 0] f3);
        return {imm[11 : 5], rs2, 5'd1, f3, imm[4 : 0], OPC_STORE};
    endfunction

    // Destinations avoid x1, which holds the RAM base; x0 appears now and then.
    function automatic logic [4 : 0] rand_rd();
        if ($urandom % 16 == 0) begin
            return 5'd0;
        end
        return 5'(2 + $urandom % 14);
    endfunction

    function automatic logic [31 : 0] alu_inst();
        case ($urandom % 11)
            0:       return r_type(F7_BASE, F3_ADD_SUB);
            1:       return r_type(F7_SUB, F3_ADD_SUB);
            2:       return r_type(F7_BASE, F3_SLT);
            3:       return r_type(F7_BASE, F3_XOR);
            4:       return r_type(F7_BASE, F3_OR);
            5:       return r_type(F7_BASE, F3_AND);
            6:       return i_type(12'($urandom), 5'($urandom % 16), F3_ADD_SUB,
                                   rand_rd(), OPC_OP_IMM);
            7:       return i_type(12'($urandom), 5'($urandom % 16), F3_XOR,
                                   rand_rd(), OPC_OP_IMM);
            8:       return i_type(12'($urandom), 5'($urandom % 16), F3_OR,
                                   rand_rd(), OPC_OP_IMM);
            9:       return i_type(12'($urandom), 5'($urandom % 16), F3_AND,
                                   rand_rd(), OPC_OP_IMM);
            default: return {20'($urandom), rand_rd(), OPC_LUI};
        endcase
    endfunction

    function automatic logic [31 : 0] mem_inst();
        case ($urandom % 4)
            0:       return s_type(12'(4 * ($urandom % 64)), 5'($urandom % 16), F3_SW);
            1:       return s_type(12'($urandom % 256), 5'($urandom % 16), F3_SB);
            2:       return i_type(12'(4 * ($urandom % 64)), 5'd1, F3_LW, rand_rd(), OPC_LOAD);
            default: return i_type(12'($urandom % 256), 5'd1, F3_LBU, rand_rd(), OPC_LOAD);
        endcase
    endfunction

    // Jumps go forward by one to four instructions; equal operands make BEQ take now and then.
    function automatic logic [31 : 0] flow_inst();
        logic [4 : 0]  rs1;
        logic [4 : 0]  rs2;
        logic [20 : 0] off;
        rs1 = 5'($urandom % 6);
        rs2 = ($urandom % 2 == 0) ? rs1 : 5'($urandom % 6);
        off = 21'(4 * (1 + $urandom % 4));
        case ($urandom % 3)
            0:       return {off[12], off[10 : 5], rs2, rs1, F3_BEQ,
                             off[4 : 1], off[11], OPC_BRANCH};
            1:       return {off[12], off[10 : 5], rs2, rs1, F3_BNE,
                             off[4 : 1], off[11], OPC_BRANCH};
            default: return {off[20], off[10 : 1], off[11], off[19 : 12], rand_rd(), OPC_JAL};
        endcase
    endfunction

    task automatic put_inst(logic [31 : 0] inst);
        rom[next_slot] = inst;
        next_slot++;
    endtask

    task automatic build_program(int kind);
        for (int i = 0; i < 256; i++) begin
            rom[i] = '0;
        end
        next_slot = 0;
        put_inst(i_type(12'(RAM_BASE), 5'd0, F3_ADD_SUB, 5'd1, OPC_OP_IMM));
        for (int r = 2; r < 16; r++) begin
            if (r % 3 == 0) begin
                put_inst({20'($urandom), 5'(r), OPC_LUI});
            end else begin
                put_inst(i_type(12'($urandom), 5'd0, F3_ADD_SUB, 5'(r), OPC_OP_IMM));
            end
        end
        for (int i = 0; i < BODY_LEN; i++) begin
            case (kind)
                0:       put_inst(alu_inst());
                1:       put_inst(($urandom % 5 < 3) ? mem_inst() : alu_inst());
                default: put_inst(($urandom % 5 < 2) ? flow_inst() : alu_inst());
            endcase
        end
        // Storing every register lets the checker see each final value.
        for (int r = 0; r < 16; r++) begin
            if (r != 1) begin
                put_inst(s_type(12'(4 * r), 5'(r), F3_SW));
            end
        end
        put_inst({F12_EBREAK, 5'd0, F3_PRIV, 5'd0, OPC_SYSTEM});
    endtask

    initial begin
        int errors_before;
        int tests_failed;
        int assert_fails;
        reset        = 1'b1;
        tests_failed = 0;
        void'($urandom(32'hb7de_42c2));
        for (int t = 0; t < NUM_TESTS; t++) begin
            errors_before = error_count;
            @(posedge clk);
            reset <= 1'b1;
            // The new program is loaded while the core already sits in reset.
            @(posedge clk);
            build_program(t % 3);
            repeat (2) @(posedge clk);
            reset <= 1'b0;
            do begin
                @(negedge clk);
            end while (!end_flag);
            #1;
            if (error_count != errors_before) begin
                tests_failed++;
            end
            $display("test %0d (%s) reached EBREAK at pc %h, x10 = %h: %s", t,
                     kind_names[t % 3], rom_rd_addr, end_data,
                     (error_count == errors_before) ? "ok" : "mismatches");
        end
        assert_fails = cpu_inst.cpu_props_inst.fail_count;
        $display("tests run %0d, tests failed %0d, check errors %0d, assertion failures %0d",
                 NUM_TESTS, tests_failed, error_count, assert_fails);
        if (tests_failed == 0 && error_count == 0 && assert_fails == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired after %0d cycles: a program never reached EBREAK",
                 WATCHDOG_CYCLES);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

/* sources.f */
logic/isa_pkg.sv
logic/core_pkg.sv
logic/decode_if.sv
logic/decode_unit.sv
logic/execute_unit.sv
logic/result_unit.sv
logic/cpu.sv
testbench/clock_gen.sv
testbench/cpu_props.sv
testbench/cpu_checker.sv
testbench/tb_cpu.sv

/* run_sim.sh */
#!/bin/sh
# Builds the testbench with Verilator, runs it and scans the log.
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_cpu \
    -f sources.f -Mdir obj_dir -o tb_cpu_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_cpu_sim +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi
if grep -q '\*\*\* FAILED \*\*\*' "$LOG"; then
    exit 1
fi
exit 0
